// ==== filelist.f ====
src/fetch_pkg.sv
src/fetch_icache_if.sv
src/fetch_icache.sv
src/fetch_stage.sv
src/fetch_top.sv
testbench/fetch_mem_model.sv
testbench/fetch_tb.sv

// ==== testbench/fetch_tb.sv ====
module fetch_tb;

	localparam int RECORD_COUNT = 28;
	localparam int RESET_CYCLES = 16;
	localparam int RECORD_LIMIT = 40;
	localparam int QUIET_CYCLES = 20;
	localparam int TIMEOUT_CYCLES = RECORD_COUNT * (4 + 4) + RESET_CYCLES + 300;

	logic clock;
	logic reset;
	logic jump;
	logic [31:0] jump_pc;
	logic irq_pending;
	logic [31:0] irq_pc;
	logic irq_dispatched;
	logic [31:0] irq_epc;
	logic decode_busy;
	logic [7:0] fetch_tag;
	logic [31:0] fetch_instruction;
	logic [31:0] fetch_pc;
	logic bus_request;
	logic [31:0] bus_address;
	logic bus_ready;
	logic [31:0] bus_rdata;
	int request_count;
	int error_count;
	logic [7:0] seen_tag;

	fetch_top fetch_top_i (
		.i_clock(clock), .i_reset(reset), .i_jump(jump), .i_jump_pc(jump_pc),
		.i_irq_pending(irq_pending), .i_irq_pc(irq_pc),
		.o_irq_dispatched(irq_dispatched), .o_irq_epc(irq_epc),
		.i_decode_busy(decode_busy), .o_fetch_tag(fetch_tag),
		.o_fetch_instruction(fetch_instruction), .o_fetch_pc(fetch_pc),
		.o_bus_request(bus_request), .o_bus_address(bus_address),
		.i_bus_ready(bus_ready), .i_bus_rdata(bus_rdata)
	);

	fetch_mem_model memory_model_i (
		.i_clock(clock), .i_bus_request(bus_request), .i_bus_address(bus_address),
		.o_bus_ready(bus_ready), .o_bus_rdata(bus_rdata), .o_request_count(request_count)
	);

	always #5 clock = ~clock;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// Wait for the next tag and check pc, word and the address of the last fill
	task automatic expect_record(input logic [31:0] exp_pc);
		int cycles;
		logic [7:0] next_tag;
		logic fill_seen;
		logic [31:0] fill_address;
		cycles = 0;
		next_tag = seen_tag + 8'd1;
		fill_seen = 1'b0;
		fill_address = '0;
		while (fetch_tag === seen_tag && cycles < RECORD_LIMIT) begin
			@(negedge clock);
			if (bus_request === 1'b1) begin
				fill_seen = 1'b1;
				fill_address = bus_address;
			end
			cycles++;
		end
		if (fetch_tag === seen_tag) begin
			$display("No fetch record for pc %h within %0d cycles at %0t",
				exp_pc, RECORD_LIMIT, $time);
			error_count++;
		end
		else begin
			check_value("o_fetch_tag", next_tag, fetch_tag);
			check_value("o_fetch_pc", exp_pc, fetch_pc);
			check_value("o_fetch_instruction", memory_model_i.memory[exp_pc[9:2]],
				fetch_instruction);
			if (fill_seen) begin
				check_value("o_bus_address", exp_pc, fill_address);
			end
			seen_tag = fetch_tag;
		end
	endtask

	task automatic expect_hold(input int cycles);
		logic [31:0] held_pc;
		logic [31:0] held_instruction;
		held_pc = fetch_pc;
		held_instruction = fetch_instruction;
		repeat (cycles) begin
			@(negedge clock);
			check_value("o_fetch_tag", seen_tag, fetch_tag);
			check_value("o_fetch_pc", held_pc, fetch_pc);
			check_value("o_fetch_instruction", held_instruction, fetch_instruction);
		end
	endtask

	task automatic jump_to(input logic [31:0] target);
		jump = 1'b1;
		jump_pc = target;
		@(negedge clock);
		jump = 1'b0;
	endtask

	// One-cycle interrupt gives exactly one cycle of dispatch
	task automatic raise_irq(input logic [31:0] target, input logic [31:0] expected_epc);
		irq_pending = 1'b1;
		irq_pc = target;
		@(negedge clock);
		irq_pending = 1'b0;
		check_value("o_irq_dispatched", 1, irq_dispatched);
		check_value("o_irq_epc", expected_epc, irq_epc);
		@(negedge clock);
		check_value("o_irq_dispatched", 0, irq_dispatched);
	endtask

	task automatic test_reset_state();
		check_value("o_bus_request", 0, bus_request);
		check_value("o_irq_dispatched", 0, irq_dispatched);
		check_value("o_fetch_tag", 0, fetch_tag);
		check_value("o_fetch_pc", 0, fetch_pc);
		check_value("o_fetch_instruction", 0, fetch_instruction);
	endtask

	// Eight ALU words followed by the branch at 0x20
	task automatic test_sequential_fetch();
		for (int i = 0; i <= 8; i++) begin
			expect_record(i * 4);
		end
	endtask

	// Refetch of lines 0 to 8 stays off the bus
	task automatic test_cache_reuse();
		int cached_requests;
		expect_hold(QUIET_CYCLES);
		cached_requests = request_count;
		jump_to(32'h0);
		test_sequential_fetch();
		check_value("request count", cached_requests, request_count);
	endtask

	task automatic test_control_stop(input logic [31:0] target);
		expect_hold(QUIET_CYCLES);
		jump_to(target);
		expect_record(target);
	endtask

	// Stage parked on wfi at 0x4c
	task automatic test_irq_waiting();
		expect_hold(QUIET_CYCLES);
		raise_irq(32'h80, 32'h4c);
		expect_record(32'h80);
	endtask

	task automatic test_decode_backpressure();
		expect_record(32'h84);
		decode_busy = 1'b1;
		expect_hold(12);
		decode_busy = 1'b0;
		expect_record(32'h88);
		expect_record(32'h8c);
	endtask

	task automatic test_irq_running();
		expect_record(32'h90);
		raise_irq(32'h100, 32'h94);
		expect_record(32'h100);
	endtask

	initial begin
		error_count = 0;
		seen_tag = 8'd0;
		clock = 1'b0;
		reset = 1'b1;
		jump = 1'b0;
		jump_pc = '0;
		irq_pending = 1'b0;
		irq_pc = '0;
		decode_busy = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock);
		test_reset_state();
		reset = 1'b0;
		test_sequential_fetch();
		test_cache_reuse();
		test_control_stop(32'h40);
		test_control_stop(32'h44);
		test_control_stop(32'h48);
		test_control_stop(32'h4c);
		test_irq_waiting();
		test_decode_backpressure();
		test_irq_running();
		$display("Checks done at %0t with %0d errors", $time, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end
		else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_CYCLES * 10);
		$display("Watchdog expired after %0d cycles with %0d errors, tests did not complete",
			TIMEOUT_CYCLES, error_count);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== testbench/fetch_mem_model.sv ====
module fetch_mem_model (
	input logic i_clock,
	input logic i_bus_request,
	input logic [31:0] i_bus_address,
	output logic o_bus_ready,
	output logic [31:0] o_bus_rdata,
	output int o_request_count
);

	localparam int unsigned RANDOM_SEED = 32'h42110b82;

	logic [31:0] memory [256];
	int wait_cycles;
	int unsigned seed;
	logic seeded;

	// ALU immediate word with the whole address folded into the upper bits
	function automatic logic [31:0] filler_word(input logic [31:0] address);
		logic [24:0] upper;
		upper = address[26:2] ^ {20'd0, address[31:27]};
		return {upper, 7'b0010011};
	endfunction

	initial begin
		for (int i = 0; i < 256; i++) begin
			memory[i] = filler_word(i * 4);
		end
		// Control-flow words at 0x20 and 0x40 to 0x4c
		memory[8'h08] = 32'h0020_8463;
		memory[8'h10] = 32'h0100_006f;
		memory[8'h11] = 32'h0000_8067;
		memory[8'h12] = 32'h3020_0073;
		memory[8'h13] = 32'h1050_0073;
		o_bus_ready = 1'b0;
		o_bus_rdata = '0;
		o_request_count = 0;
		wait_cycles = -1;
		seed = RANDOM_SEED;
		seeded = 1'b0;
	end

	// Answer after 0 to 3 cycles with a one-cycle ready pulse
	always @(negedge i_clock) begin
		if (o_bus_ready) begin
			o_bus_ready <= 1'b0;
		end
		else if (i_bus_request) begin
			if (wait_cycles < 0) begin
				// First draw also seeds the generator of this process
				if (seeded) begin
					wait_cycles = $urandom % 4;
				end
				else begin
					wait_cycles = $urandom(seed) % 4;
					seeded = 1'b1;
				end
			end
			if (wait_cycles == 0) begin
				o_bus_ready <= 1'b1;
				o_bus_rdata <= memory[i_bus_address[9:2]];
				o_request_count <= o_request_count + 1;
			end
			wait_cycles = wait_cycles - 1;
		end
	end

endmodule

// ==== src/fetch_top.sv ====
module fetch_top (
	input logic i_clock,
	input logic i_reset,

	// Execute side
	input logic i_jump,
	input logic [31:0] i_jump_pc,

	// Interrupt
	input logic i_irq_pending,
	input logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,

	// Decode side
	input logic i_decode_busy,
	output logic [fetch_pkg::FETCH_TAG_BITS-1:0] o_fetch_tag,
	output logic [31:0] o_fetch_instruction,
	output logic [31:0] o_fetch_pc,

	// Fill bus
	output logic o_bus_request,
	output logic [31:0] o_bus_address,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata
);

	fetch_pkg::fetch_data_t fetch_data;

	fetch_icache_if icache_bus ();

	fetch_stage fetch_stage_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.i_decode_busy(i_decode_busy),
		.o_data(fetch_data),
		.icache(icache_bus.stage)
	);

	fetch_icache fetch_icache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.cache(icache_bus.cache),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	// Record split for decode
	assign o_fetch_tag = fetch_data.tag;
	assign o_fetch_instruction = fetch_data.instruction;
	assign o_fetch_pc = fetch_data.pc;

endmodule

// ==== src/fetch_stage.sv ====
module fetch_stage (
	input logic i_clock,
	input logic i_reset,

	// Execute side redirect
	input logic i_jump,
	input logic [31:0] i_jump_pc,

	// Interrupt
	input logic i_irq_pending,
	input logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,

	// Decode side
	input logic i_decode_busy,
	output fetch_pkg::fetch_data_t o_data,

	// Instruction cache
	fetch_icache_if.stage icache
);

	typedef enum logic {
		STATE_RUNNING,
		STATE_WAITING
	} state_t;

	state_t state;
	logic [31:0] pc;

	// Fields of the word coming from the cache
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [11:0] funct12;

	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic is_mret;
	logic is_wfi;
	logic is_stop;
	logic take_word;

	assign opcode = icache.rdata[6:0];
	assign funct3 = icache.rdata[14:12];
	assign funct12 = icache.rdata[31:20];

	// Control-flow classification
	always_comb begin
		is_jal = (opcode == fetch_pkg::OPCODE_JAL);
		is_jalr = (opcode == fetch_pkg::OPCODE_JALR);
		is_branch = (opcode == fetch_pkg::OPCODE_BRANCH);
		is_mret = (opcode == fetch_pkg::OPCODE_SYSTEM) && (funct3 == 3'b000)
			&& (funct12 == fetch_pkg::FUNCT12_MRET);
		is_wfi = (opcode == fetch_pkg::OPCODE_SYSTEM) && (funct3 == 3'b000)
			&& (funct12 == fetch_pkg::FUNCT12_WFI);
		is_stop = is_jal || is_jalr || is_branch || is_mret || is_wfi;
	end

	// Stall also holds off new cache fills
	assign icache.stall = i_decode_busy || (state != STATE_RUNNING);
	assign icache.pc = pc;

	assign take_word = icache.ready && !icache.stall;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= STATE_RUNNING;
			pc <= fetch_pkg::RESET_PC;
			o_data <= '0;
			o_irq_dispatched <= 1'b0;
			o_irq_epc <= '0;
		end
		else begin
			o_irq_dispatched <= 1'b0;

			// Interrupt wins over fetch and jump
			if (i_irq_pending) begin
				o_irq_dispatched <= 1'b1;
				o_irq_epc <= pc;
				pc <= i_irq_pc;
				state <= STATE_RUNNING;
			end
			else begin
				case (state)
					STATE_RUNNING: begin
						if (take_word) begin
							o_data.tag <= o_data.tag + 1'b1;
							o_data.instruction <= icache.rdata;
							o_data.pc <= pc;

							// Target unknown here, park until execute resolves it
							if (is_stop) begin
								state <= STATE_WAITING;
							end
							else begin
								pc <= pc + 32'd4;
							end
						end
					end

					STATE_WAITING: begin
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= STATE_RUNNING;
						end
					end

					default: begin
						state <= STATE_RUNNING;
					end
				endcase
			end
		end
	end

endmodule

// ==== src/fetch_icache.sv ====
module fetch_icache (
	input logic i_clock,
	input logic i_reset,

	// Fetch stage side
	fetch_icache_if.cache cache,

	// Fill bus
	output logic o_bus_request,
	output logic [31:0] o_bus_address,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata
);

	localparam int INDEX_BITS = fetch_pkg::ICACHE_INDEX_BITS;
	localparam int TAG_BITS = fetch_pkg::ICACHE_TAG_BITS;
	localparam int LINES = fetch_pkg::ICACHE_LINES;

	// Line storage
	logic [LINES-1:0] line_valid;
	logic [TAG_BITS-1:0] line_tag [LINES];
	logic [31:0] line_word [LINES];

	// Lookup for the current pc
	logic [INDEX_BITS-1:0] lookup_index;
	logic [TAG_BITS-1:0] lookup_tag;
	logic hit;

	// Fill target comes from the latched bus address
	logic [INDEX_BITS-1:0] fill_index;
	logic [TAG_BITS-1:0] fill_tag;
	logic fill_start;
	logic fill_done;

	assign lookup_index = cache.pc[INDEX_BITS+1:2];
	assign lookup_tag = cache.pc[31:INDEX_BITS+2];

	assign fill_index = o_bus_address[INDEX_BITS+1:2];
	assign fill_tag = o_bus_address[31:INDEX_BITS+2];

	always_comb begin
		hit = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);
	end

	// Hit path is purely combinational
	assign cache.ready = hit;
	assign cache.rdata = line_word[lookup_index];

	// New fill only when idle, missing and the stage wants a word
	assign fill_start = !o_bus_request && !hit && !cache.stall;

	// Bus data accepted, line written on this edge
	assign fill_done = o_bus_request && i_bus_ready;

	// Request level and valid bits
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_bus_request <= 1'b0;
			line_valid <= '0;
		end
		else begin
			if (fill_done) begin
				o_bus_request <= 1'b0;
				line_valid[fill_index] <= 1'b1;
			end
			else if (fill_start) begin
				// Stays up until the bus answers, even if stall rises
				o_bus_request <= 1'b1;
			end
		end
	end

	// Missing address is held for the whole fill
	always_ff @(posedge i_clock) begin
		if (fill_start) begin
			o_bus_address <= {cache.pc[31:2], 2'b00};
		end
	end

	// Tag and word arrays
	always_ff @(posedge i_clock) begin
		if (fill_done) begin
			line_tag[fill_index] <= fill_tag;
			line_word[fill_index] <= i_bus_rdata;
		end
	end

endmodule

// ==== src/fetch_icache_if.sv ====
interface fetch_icache_if;

	// Address the stage wants next
	logic [31:0] pc;

	// Stage cannot take a word this cycle
	logic stall;

	// Cached word for pc, valid while ready is high
	logic [31:0] rdata;
	logic ready;

	modport stage (
		output pc,
		output stall,
		input rdata,
		input ready
	);

	modport cache (
		input pc,
		input stall,
		output rdata,
		output ready
	);

endinterface

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

	// Start address after reset
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// Record given to decode
	localparam int FETCH_TAG_BITS = 8;

	typedef struct packed {
		logic [FETCH_TAG_BITS-1:0] tag;
		logic [31:0] instruction;
		logic [31:0] pc;
	} fetch_data_t;

	// Cache geometry, one word per line
	localparam int ICACHE_LINES = 16;
	localparam int ICACHE_INDEX_BITS = 4;

	// Tag covers the pc above the index and the byte offset
	localparam int ICACHE_TAG_BITS = 32 - ICACHE_INDEX_BITS - 2;

	// Major opcodes that end a fetch run
	localparam logic [6:0] OPCODE_JAL = 7'b1101111;
	localparam logic [6:0] OPCODE_JALR = 7'b1100111;
	localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
	localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

	// Privileged system functions in bits 31:20
	localparam logic [11:0] FUNCT12_MRET = 12'h302;
	localparam logic [11:0] FUNCT12_WFI = 12'h105;

endpackage
